/* common/buffer_consts.svh */
`ifndef BUFFER_CONSTS_SVH
`define BUFFER_CONSTS_SVH

// data fifo, 16 entries
`define DATA_FIFO_AW 4
// almost thresholds on the data side
`define DATA_FIFO_N 4

// info fifo holds one record per frame, 4 entries
`define INFO_FIFO_AW 2
`define INFO_FIFO_N 1

// payload field widths
`define SAMPLE_W 32
`define FRAME_LEN_W 8
`define DROP_CNT_W 8

`endif

/* common/fifo_pkg.sv */
package fifo_pkg;

	// status flags of one fifo instance
	// combinational flags follow the pointers and the counter directly
	// the _r versions come straight out of flops and match them cycle for cycle
	typedef struct packed {
		// count equals depth
		logic full;
		// count is zero
		logic empty;
		logic full_r;
		logic empty_r;
		// count at least depth - n + 1
		logic full_n;
		// count below n
		logic empty_n;
		logic full_n_r;
		logic empty_n_r;
		// coarse fill level, 3 when full
		logic [1:0] level;
	} fifo_status_t;

endpackage

/* common/frame_pkg.sv */
`include "buffer_consts.svh"

package frame_pkg;

	// one sample as written by the producer
	// last marks the final sample of a frame
	typedef struct packed {
		logic [`SAMPLE_W-1:0] value;
		logic last;
	} sample_t;

	// one record per accepted frame
	// length counts the accepted samples including the last one, mod 256
	typedef struct packed {
		logic [`FRAME_LEN_W-1:0] id;
		logic [`FRAME_LEN_W-1:0] length;
	} frame_info_t;

endpackage

/* fifo/fifo_ram.sv */
`timescale 1ns/1ps

// storage for fifo_sc
// one write port and one registered read port on the same clock
module fifo_ram #(
	parameter int AW = 4,
	parameter type payload_t = logic [7:0]
) (
	input  logic clk,
	input  logic wr_en,
	input  logic [AW-1:0] wr_addr,
	input  payload_t wr_data,
	input  logic rd_en,
	input  logic [AW-1:0] rd_addr,
	output payload_t rd_data
);

	localparam int DEPTH = 1 << AW;

	payload_t mem [0:DEPTH-1];

	// nonblocking read and write in the same block
	// a read of the slot being written returns the old entry
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// rd_data holds between reads
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* fifo/fifo_sc.sv */
`timescale 1ns/1ps

// single clock fifo with the full flag set
// writes are not guarded here, the producer side must not write when full
// a read strobe while empty is ignored
module fifo_sc #(
	parameter int AW = 4,
	parameter int N = 1,
	parameter type payload_t = logic [7:0]
) (
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic we,
	input  payload_t din,
	input  logic re,
	output payload_t dout,
	output fifo_pkg::fifo_status_t status
);

	// counter sized constants, one bit wider than the pointers
	localparam logic [AW:0] DEPTH = {1'b1, {AW{1'b0}}};
	localparam logic [AW:0] ONE = (AW+1)'(1);
	localparam logic [AW:0] N_W = (AW+1)'(N);
	// pointer steps
	localparam logic [AW-1:0] P1 = AW'(1);
	localparam logic [AW-1:0] P2 = AW'(2);

	logic [AW-1:0] wp;
	logic [AW-1:0] wp_pl1;
	logic [AW-1:0] wp_pl2;
	logic [AW-1:0] rp;
	logic [AW-1:0] rp_pl1;
	logic [AW:0] cnt;
	logic gb;
	logic gb2;
	logic rd;
	logic wr_only;
	logic rd_only;
	logic full;
	logic empty;
	logic full_r;
	logic empty_r;
	logic full_n;
	logic empty_n;
	logic full_n_r;
	logic empty_n_r;
	logic [1:0] level;

	////////////////////////////////////////////////////////////////////////////
	// strobes and pointers

	// effective read only when something is stored
	assign rd = re & ~empty;
	// a write and a read together leave every flag where it is
	assign wr_only = we & ~rd;
	assign rd_only = rd & ~we;

	assign wp_pl1 = wp + P1;
	assign wp_pl2 = wp + P2;
	assign rp_pl1 = rp + P1;

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			wp <= '0;
			rp <= '0;
		end else begin
			if (we) begin
				wp <= wp_pl1;
			end
			if (rd) begin
				rp <= rp_pl1;
			end
		end
	end

	// popped entry lands on dout right after the read edge
	fifo_ram #(
		.AW(AW),
		.payload_t(payload_t)
	) ram0 (
		.clk(clk),
		.wr_en(we),
		.wr_addr(wp),
		.wr_data(din),
		.rd_en(rd),
		.rd_addr(rp),
		.rd_data(dout)
	);

	////////////////////////////////////////////////////////////////////////////
	// guard bits

	// gb tells full from empty when the pointers meet
	// gb2 is set while count is depth-1 or depth
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			gb <= 1'b0;
			gb2 <= 1'b0;
		end else begin
			if (wr_only && (wp_pl1 == rp)) begin
				gb <= 1'b1;
			end else if (rd_only) begin
				gb <= 1'b0;
			end
			// depth-2 to depth-1 sets, depth-1 to depth-2 clears
			if (wr_only && (wp_pl2 == rp)) begin
				gb2 <= 1'b1;
			end else if (rd_only && (wp_pl1 == rp)) begin
				gb2 <= 1'b0;
			end
		end
	end

	assign empty = (wp == rp) & ~gb;
	assign full = (wp == rp) & gb;

	////////////////////////////////////////////////////////////////////////////
	// entry counter and threshold flags

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			cnt <= '0;
		end else if (wr_only) begin
			cnt <= cnt + ONE;
		end else if (rd_only) begin
			cnt <= cnt - ONE;
		end
	end

	assign empty_n = cnt < N_W;
	assign full_n = cnt >= (DEPTH - N_W + ONE);
	// msb of cnt is only set when full, which forces level to 3
	assign level = {cnt[AW], cnt[AW]} | cnt[AW-1:AW-2];

	////////////////////////////////////////////////////////////////////////////
	// registered flags, each one edge ahead of its next value

	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			full_r <= 1'b0;
			empty_r <= 1'b1;
			full_n_r <= 1'b0;
			empty_n_r <= 1'b1;
		end else begin
			// write into the last free slot
			if (wr_only && (wp_pl1 == rp) && gb2) begin
				full_r <= 1'b1;
			end else if (rd_only) begin
				full_r <= 1'b0;
			end
			// read of the only stored entry
			if (wr_only) begin
				empty_r <= 1'b0;
			end else if (rd_only && (wp == rp_pl1)) begin
				empty_r <= 1'b1;
			end
			// count reaches n on this write
			if (wr_only && (cnt >= (N_W - ONE))) begin
				empty_n_r <= 1'b0;
			end else if (rd_only && (cnt <= N_W)) begin
				empty_n_r <= 1'b1;
			end
			// count reaches depth-n+1 on this write
			if (wr_only && (cnt >= (DEPTH - N_W))) begin
				full_n_r <= 1'b1;
			end else if (rd_only && (cnt <= (DEPTH - N_W + ONE))) begin
				full_n_r <= 1'b0;
			end
		end
	end

	assign status = '{
		full: full,
		empty: empty,
		full_r: full_r,
		empty_r: empty_r,
		full_n: full_n,
		empty_n: empty_n,
		full_n_r: full_n_r,
		empty_n_r: empty_n_r,
		level: level
	};

endmodule

/* hw/frame_tracker.sv */
`timescale 1ns/1ps
`include "buffer_consts.svh"

// decides per sample whether the frame buffer takes it
// writes one info record when the last sample of a frame goes in
module frame_tracker (
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic in_we,
	input  frame_pkg::sample_t in_sample,
	input  fifo_pkg::fifo_status_t data_status,
	input  fifo_pkg::fifo_status_t info_status,
	output logic data_we,
	output frame_pkg::sample_t data_din,
	output logic info_we,
	output frame_pkg::frame_info_t info_din,
	output logic [`DROP_CNT_W-1:0] drop_count
);
	import frame_pkg::*;

	localparam logic [`FRAME_LEN_W-1:0] LEN_ONE = {{(`FRAME_LEN_W-1){1'b0}}, 1'b1};
	localparam logic [`DROP_CNT_W-1:0] DROP_ONE = {{(`DROP_CNT_W-1){1'b0}}, 1'b1};

	logic accept;
	logic [`FRAME_LEN_W-1:0] frame_len;
	logic [`FRAME_LEN_W-1:0] frame_id;
	frame_info_t rec;

	// no room for the sample, or a last sample with no room for its record
	assign accept = in_we & ~data_status.full & ~(in_sample.last & info_status.full);

	assign data_we = accept;
	assign data_din = in_sample;
	assign info_we = accept & in_sample.last;

	// record for the frame closed by this sample
	assign rec.id = frame_id;
	assign rec.length = frame_len + LEN_ONE;
	assign info_din = rec;

	////////////////////////////////////////////////////////////////////////////
	// frame counters

	// running length of the open frame, flushed by clr
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			frame_len <= '0;
		end else if (accept) begin
			frame_len <= in_sample.last ? '0 : frame_len + LEN_ONE;
		end
	end

	// id and drop count survive clr
	always_ff @(posedge clk) begin
		if (!rst) begin
			frame_id <= '0;
			drop_count <= '0;
		end else begin
			if (info_we) begin
				frame_id <= frame_id + LEN_ONE;
			end
			// saturates at all ones
			if (in_we && !accept && (drop_count != '1)) begin
				drop_count <= drop_count + DROP_ONE;
			end
		end
	end

endmodule

/* hw/frame_buffer_top.sv */
`timescale 1ns/1ps
`include "buffer_consts.svh"

// frame capture buffer
// samples go to the data fifo, one record per frame goes to the info fifo
module frame_buffer_top (
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic in_we,
	input  frame_pkg::sample_t in_sample,
	input  logic data_re,
	output frame_pkg::sample_t data_out,
	output fifo_pkg::fifo_status_t data_status,
	input  logic info_re,
	output frame_pkg::frame_info_t info_out,
	output fifo_pkg::fifo_status_t info_status,
	output logic [`DROP_CNT_W-1:0] drop_count
);
	import frame_pkg::*;

	// tracker to fifo write side
	logic data_we;
	sample_t data_din;
	logic info_we;
	frame_info_t info_din;

	// accept test against both fifo states, in the same cycle
	frame_tracker frame_tracker0 (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.in_we(in_we),
		.in_sample(in_sample),
		.data_status(data_status),
		.info_status(info_status),
		.data_we(data_we),
		.data_din(data_din),
		.info_we(info_we),
		.info_din(info_din),
		.drop_count(drop_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// sample storage
	fifo_sc #(
		.AW(`DATA_FIFO_AW),
		.N(`DATA_FIFO_N),
		.payload_t(sample_t)
	) data_fifo0 (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.we(data_we),
		.din(data_din),
		.re(data_re),
		.dout(data_out),
		.status(data_status)
	);

	////////////////////////////////////////////////////////////////////////////
	// frame records, shallower than the data side
	fifo_sc #(
		.AW(`INFO_FIFO_AW),
		.N(`INFO_FIFO_N),
		.payload_t(frame_info_t)
	) info_fifo0 (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.we(info_we),
		.din(info_din),
		.re(info_re),
		.dout(info_out),
		.status(info_status)
	);

endmodule

/* bench/frame_buffer_assertions.sv */
`timescale 1ns/1ps

// flag relations of one fifo_sc instance
module frame_buffer_assertions (
	input logic clk,
	input logic rst,
	input fifo_pkg::fifo_status_t status
);
	import fifo_pkg::*;

	// number of failed assertions in this instance
	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// registered flags track their combinational versions

	a_full_r: assert property (@(posedge clk) disable iff (!rst) status.full_r == status.full)
		else begin
			fail_count++;
			$error("full_r differs from full");
		end

	a_empty_r: assert property (@(posedge clk) disable iff (!rst)
		status.empty_r == status.empty)
		else begin
			fail_count++;
			$error("empty_r differs from empty");
		end

	a_full_n_r: assert property (@(posedge clk) disable iff (!rst)
		status.full_n_r == status.full_n)
		else begin
			fail_count++;
			$error("full_n_r differs from full_n");
		end

	a_empty_n_r: assert property (@(posedge clk) disable iff (!rst)
		status.empty_n_r == status.empty_n)
		else begin
			fail_count++;
			$error("empty_n_r differs from empty_n");
		end

	// full and empty exclude each other in both their forms
	a_full_empty: assert property (@(posedge clk) disable iff (!rst)
		!(status.full && status.empty) && !(status.full_r && status.empty_r))
		else begin
			fail_count++;
			$error("full and empty both set");
		end

	// level saturates when full
	a_level: assert property (@(posedge clk) disable iff (!rst)
		status.full |-> (status.level == 2'd3))
		else begin
			fail_count++;
			$error("level is not 3 while full");
		end

endmodule

// one checker per fifo instance
bind fifo_sc frame_buffer_assertions asrt0 (
	.clk(clk),
	.rst(rst),
	.status(status)
);

/* bench/frame_buffer_tb.sv */
`timescale 1ns/1ps
`include "buffer_consts.svh"

module frame_buffer_tb;
	import fifo_pkg::*;
	import frame_pkg::*;

	localparam int DATA_DEPTH = 1 << `DATA_FIFO_AW;
	localparam int INFO_DEPTH = 1 << `INFO_FIFO_AW;
	localparam int DRAIN_LIMIT = 64;
	localparam logic [`FRAME_LEN_W-1:0] LEN_STEP = {{(`FRAME_LEN_W-1){1'b0}}, 1'b1};
	localparam logic [`DROP_CNT_W-1:0] DROP_STEP = {{(`DROP_CNT_W-1){1'b0}}, 1'b1};

	logic clk;
	logic rst;
	logic clr;
	logic in_we;
	sample_t in_sample;
	logic data_re;
	logic info_re;
	sample_t data_out;
	fifo_status_t data_status;
	frame_info_t info_out;
	fifo_status_t info_status;
	logic [`DROP_CNT_W-1:0] drop_count;

	// reference state with one queue per fifo
	sample_t data_q[$];
	frame_info_t info_q[$];
	sample_t exp_data;
	frame_info_t exp_info;
	// dout is only known once something was popped
	logic data_seen;
	logic info_seen;
	logic [`FRAME_LEN_W-1:0] model_len;
	logic [`FRAME_LEN_W-1:0] model_id;
	logic [`DROP_CNT_W-1:0] model_drops;

	int mismatch_count;
	int timeout_count;
	int assert_count;
	integer seed;

	frame_buffer_top dut0 (
		.clk(clk),
		.rst(rst),
		.clr(clr),
		.in_we(in_we),
		.in_sample(in_sample),
		.data_re(data_re),
		.data_out(data_out),
		.data_status(data_status),
		.info_re(info_re),
		.info_out(info_out),
		.info_status(info_status),
		.drop_count(drop_count)
	);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model

	// flags of a fifo holding count entries
	function automatic fifo_status_t expect_status(input int count, input int depth, input int n);
		fifo_status_t s;
		s.full = (count == depth);
		s.empty = (count == 0);
		s.full_n = (count >= depth - n + 1);
		s.empty_n = (count < n);
		// registered copies match in every cycle
		s.full_r = s.full;
		s.empty_r = s.empty;
		s.full_n_r = s.full_n;
		s.empty_n_r = s.empty_n;
		// top two bits of the count and 3 when full
		s.level = s.full ? 2'd3 : 2'((count * 4) / depth);
		return s;
	endfunction

	// one clock edge of tracker and both fifos
	task automatic model_step();
		logic acc;
		frame_info_t rec;
		if (!rst) begin
			data_q.delete();
			info_q.delete();
			model_len = '0;
			model_id = '0;
			model_drops = '0;
			data_seen = 1'b0;
			info_seen = 1'b0;
		end else if (clr) begin
			// id and drops survive a flush
			data_q.delete();
			info_q.delete();
			model_len = '0;
		end else begin
			acc = in_we && (data_q.size() != DATA_DEPTH)
				&& !(in_sample.last && (info_q.size() == INFO_DEPTH));
			// reads see the state before this edge and do nothing on an empty queue
			if (data_re && data_q.size() > 0) begin
				exp_data = data_q.pop_front();
				data_seen = 1'b1;
			end
			if (info_re && info_q.size() > 0) begin
				exp_info = info_q.pop_front();
				info_seen = 1'b1;
			end
			if (acc) begin
				data_q.push_back(in_sample);
				if (in_sample.last) begin
					rec.id = model_id;
					rec.length = model_len + LEN_STEP;
					info_q.push_back(rec);
					model_id = model_id + LEN_STEP;
					model_len = '0;
				end else begin
					model_len = model_len + LEN_STEP;
				end
			end else if (in_we && model_drops != '1) begin
				model_drops = model_drops + DROP_STEP;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare tasks

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_info(input string name, input frame_info_t exp, input frame_info_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("FAIL %0t ns %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input fifo_status_t exp,
		input fifo_status_t act);
		if (act !== exp) begin
			mismatch_count++;
			$display("FAIL %0t ns %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_drops(input string name, input logic [`DROP_CNT_W-1:0] exp,
		input logic [`DROP_CNT_W-1:0] act);
		if (act !== exp) begin
			mismatch_count++;
			$display("FAIL %0t ns %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	// outputs only depend on state, so they are settled 1 ns after the edge
	always @(posedge clk) begin
		#1;
		model_step();
		check_status("data_status", expect_status(data_q.size(), DATA_DEPTH, `DATA_FIFO_N),
			data_status);
		check_status("info_status", expect_status(info_q.size(), INFO_DEPTH, `INFO_FIFO_N),
			info_status);
		check_drops("drop_count", model_drops, drop_count);
		if (data_seen) begin
			check_sample("data_out", exp_data, data_out);
		end
		if (info_seen) begin
			check_info("info_out", exp_info, info_out);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus steps start and end on a falling edge

	task automatic write_sample(input logic [`SAMPLE_W-1:0] value, input logic last);
		in_we = 1'b1;
		in_sample.value = value;
		in_sample.last = last;
		@(negedge clk);
		in_we = 1'b0;
	endtask

	task automatic write_frame(input int len);
		int k;
		logic [`SAMPLE_W-1:0] v;
		for (k = 0; k < len; k++) begin
			v = $random(seed);
			write_sample(v, k == len - 1);
		end
	endtask

	// read both fifos until empty
	task automatic drain_fifos(input int limit);
		int n;
		n = 0;
		data_re = 1'b1;
		info_re = 1'b1;
		while (!(data_status.empty && info_status.empty) && n < limit) begin
			@(negedge clk);
			n++;
		end
		data_re = 1'b0;
		info_re = 1'b0;
		if (!(data_status.empty && info_status.empty)) begin
			timeout_count++;
			$display("timeout at %0t ns, fifos still hold entries after %0d reads", $time, n);
		end
	endtask

	task automatic pulse_clear();
		clr = 1'b1;
		@(negedge clk);
		clr = 1'b0;
	endtask

	initial begin
		int i;
		logic [31:0] rnd;
		logic [`SAMPLE_W-1:0] v;
		logic [`DROP_CNT_W-1:0] drops_before;
		seed = 32'hbaf3;
		mismatch_count = 0;
		timeout_count = 0;
		rst = 1'b0;
		clr = 1'b0;
		in_we = 1'b0;
		in_sample = '0;
		data_re = 1'b0;
		info_re = 1'b0;
		// reset held over two rising edges
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		// frames of 1 to 5 samples read back in order
		for (i = 0; i < 4; i++) begin
			rnd = $random(seed);
			write_frame(1 + int'(rnd[1:0]) + int'(rnd[2]));
			write_frame(1 + int'(rnd[4:3]) + int'(rnd[5]));
			write_frame(1 + int'(rnd[7:6]) + int'(rnd[8]));
			drain_fifos(DRAIN_LIMIT);
		end

		// fill the data fifo so that the last four writes are dropped
		for (i = 0; i < DATA_DEPTH + 4; i++) begin
			v = $random(seed);
			write_sample(v, 1'b0);
		end
		drain_fifos(DRAIN_LIMIT);

		// five single sample frames where the fifth finds the info fifo full
		drops_before = model_drops;
		for (i = 0; i < INFO_DEPTH + 1; i++) begin
			v = $random(seed);
			write_sample(v, 1'b1);
		end
		check_drops("drop_count", drops_before + DROP_STEP, drop_count);
		drain_fifos(DRAIN_LIMIT);

		// random traffic where reads often hit an empty fifo
		for (i = 0; i < 300; i++) begin
			rnd = $random(seed);
			in_we = rnd[0];
			in_sample.value = $random(seed);
			in_sample.last = (rnd[3:1] == 3'd0);
			data_re = rnd[4];
			info_re = rnd[6] & rnd[7];
			@(negedge clk);
		end
		in_we = 1'b0;
		drain_fifos(DRAIN_LIMIT);

		// flush in the middle of a frame while the id keeps counting
		write_frame(2);
		for (i = 0; i < 3; i++) begin
			v = $random(seed);
			write_sample(v, 1'b0);
		end
		pulse_clear();
		write_frame(2);
		drain_fifos(DRAIN_LIMIT);
		repeat (2) @(negedge clk);

		assert_count = dut0.data_fifo0.asrt0.fail_count + dut0.info_fifo0.asrt0.fail_count;
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatch_count, timeout_count, assert_count);
		if (mismatch_count == 0 && timeout_count == 0 && assert_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+common
common/fifo_pkg.sv
common/frame_pkg.sv
fifo/fifo_ram.sv
fifo/fifo_sc.sv
hw/frame_tracker.sv
hw/frame_buffer_top.sv
bench/frame_buffer_assertions.sv
bench/frame_buffer_tb.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert
TOP   := frame_buffer_tb
FLIST := compile.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
